/* rtl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and address width
`define XLEN 32

// register number width for 32 GPRs
`define REG_AW 5

// boot ROM entry
`define RESET_PC 32'hBFC00000

// sequential fetch increment
`define PC_STEP 4

`endif

/* rtl/isaPkg.sv */
package isaPkg;

    // major opcodes, anything else retires as a no-op
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcodeE;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI    // passes the pre-shifted immediate
    } aluOpE;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE
    } branchE;

    typedef struct packed {
        aluOpE  aluOp;
        branchE branch;
        logic   jump;
        logic   useImm;      // operand B from immediate
        logic   immZeroExt;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   dstRt;       // write rt instead of rd
    } ctrlT;

endpackage

/* rtl/pipePkg.sv */
`include "cpu_defines.svh"

package pipePkg;

    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        isaPkg::ctrlT        ctrl;
        logic [`XLEN-1:0]    opA;
        logic [`XLEN-1:0]    opB;        // imm or rt, branch offset for beq/bne
        logic [`XLEN-1:0]    storeData;  // forwarded rt
        logic [`REG_AW-1:0]  dest;
    } idExT;

    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic [`REG_AW-1:0]  dest;
        logic [`XLEN-1:0]    result;     // alu result or data address
        logic [`XLEN-1:0]    storeData;
    } exMemT;

    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        logic                regWrite;
        logic [`REG_AW-1:0]  dest;
        logic [`XLEN-1:0]    result;
    } memWbT;

    // data memory request, en is a single-cycle pulse
    typedef struct packed {
        logic                en;
        logic                we;
        logic [`XLEN-1:0]    addr;
        logic [`XLEN-1:0]    wdata;
    } memReqT;

    typedef struct packed {
        logic [`XLEN-1:0]    pc;
        logic                wen;
        logic [`REG_AW-1:0]  wnum;
        logic [`XLEN-1:0]    wdata;
    } debugWbT;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_WAIT
    } seqStateE;

endpackage

/* rtl/pcCounter.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module pcCounter (
    input  logic              clk,
    input  logic              rstN_i,
    input  logic              hold_i,
    input  logic              redirect_i,
    input  logic [`XLEN-1:0]  target_i,
    output logic [`XLEN-1:0]  pc_o
);

    logic [`XLEN-1:0] pcQ;
    logic [`XLEN-1:0] pcNext;

    // redirect beats hold, a taken branch must not be lost
    always_comb begin
        if (redirect_i) begin
            pcNext = target_i;
        end else if (hold_i) begin
            pcNext = pcQ;
        end else begin
            pcNext = pcQ + `PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcQ <= `RESET_PC;
        end else begin
            pcQ <= pcNext;
        end
    end

    assign pc_o = pcQ;

endmodule

/* rtl/decoder.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decoder (
    input  logic [31:0]         inst_i,
    output isaPkg::ctrlT        ctrl_o,
    output logic [`XLEN-1:0]    imm_o,
    output logic [`REG_AW-1:0]  rs_o,
    output logic [`REG_AW-1:0]  rt_o,
    output logic [`REG_AW-1:0]  rd_o,
    output logic [`XLEN-1:0]    jumpTarget_o
);
    import isaPkg::*;

    opcodeE opcode;
    functE  funct;

    assign opcode = opcodeE'(inst_i[31:26]);
    assign funct  = functE'(inst_i[5:0]);

    assign rs_o = inst_i[25:21];
    assign rt_o = inst_i[20:16];
    assign rd_o = inst_i[15:11];

    // region bits are merged in by the top
    assign jumpTarget_o = {{(`XLEN-28){1'b0}}, inst_i[25:0], 2'b00};

    always_comb begin
        ctrl_o        = '0;     // default is a no-op
        ctrl_o.aluOp  = ALU_ADD;
        ctrl_o.branch = BR_NONE;
        case (opcode)
            OP_SPECIAL: begin
                ctrl_o.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    FN_AND:  ctrl_o.aluOp = ALU_AND;
                    FN_OR:   ctrl_o.aluOp = ALU_OR;
                    FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    default: ctrl_o.regWrite = 1'b0;  // unsupported funct
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.dstRt    = 1'b1;
            end
            OP_ORI: begin
                ctrl_o.aluOp      = ALU_OR;
                ctrl_o.useImm     = 1'b1;
                ctrl_o.immZeroExt = 1'b1;
                ctrl_o.regWrite   = 1'b1;
                ctrl_o.dstRt      = 1'b1;
            end
            OP_LUI: begin
                ctrl_o.aluOp    = ALU_LUI;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.dstRt    = 1'b1;
            end
            OP_LW: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.memRead  = 1'b1;
                ctrl_o.dstRt    = 1'b1;
            end
            OP_SW: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.memWrite = 1'b1;
            end
            OP_BEQ: begin
                ctrl_o.branch = BR_BEQ;
                ctrl_o.useImm = 1'b1;   // offset rides in operand B
            end
            OP_BNE: begin
                ctrl_o.branch = BR_BNE;
                ctrl_o.useImm = 1'b1;
            end
            OP_J:    ctrl_o.jump = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        if (opcode == OP_LUI) begin
            imm_o = {inst_i[15:0], {(`XLEN-16){1'b0}}};
        end else if (ctrl_o.immZeroExt) begin
            imm_o = {{(`XLEN-16){1'b0}}, inst_i[15:0]};
        end else begin
            imm_o = {{(`XLEN-16){inst_i[15]}}, inst_i[15:0]};
        end
    end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic [`REG_AW-1:0]  rs_i,
    input  logic [`REG_AW-1:0]  rt_i,
    input  logic [`REG_AW-1:0]  wAddr_i,
    input  logic                wEn_i,
    input  logic [`XLEN-1:0]    wData_i,
    output logic [`XLEN-1:0]    rsData_o,
    output logic [`XLEN-1:0]    rtData_o
);

    logic [`XLEN-1:0] regs [32];
    logic             doWrite;

    assign doWrite = wEn_i && (wAddr_i != '0);  // $zero is never stored

    always_ff @(posedge clk) begin
        if (rstN_i && doWrite) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // same-cycle write shows through to decode
    assign rsData_o = (rs_i == '0) ? '0 :
                      (doWrite && wAddr_i == rs_i) ? wData_i : regs[rs_i];
    assign rtData_o = (rt_i == '0) ? '0 :
                      (doWrite && wAddr_i == rt_i) ? wData_i : regs[rt_i];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu (
    input  isaPkg::aluOpE      op_i,
    input  isaPkg::branchE     branch_i,
    input  logic [`XLEN-1:0]   a_i,
    input  logic [`XLEN-1:0]   b_i,
    input  logic [`XLEN-1:0]   cmpA_i,
    input  logic [`XLEN-1:0]   cmpB_i,
    output logic [`XLEN-1:0]   result_o,
    output logic               taken_o
);
    import isaPkg::*;

    logic lessThan;

    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {{(`XLEN-1){1'b0}}, lessThan};
            ALU_LUI: result_o = b_i;     // decoder already shifted it up
            default: result_o = a_i + b_i;
        endcase
    end

    // compare the raw register operands, not the alu inputs
    always_comb begin
        case (branch_i)
            BR_BEQ:  taken_o = (cmpA_i == cmpB_i);
            BR_BNE:  taken_o = (cmpA_i != cmpB_i);
            default: taken_o = 1'b0;
        endcase
    end

endmodule

/* rtl/memAccessSeq.sv */
`timescale 1ns/1ps

module memAccessSeq (
    input  logic clk,
    input  logic rstN_i,
    input  logic access_i,
    input  logic dStall_i,
    output logic reqEn_o,
    output logic busy_o,
    output logic done_o
);
    import pipePkg::*;

    seqStateE state;
    seqStateE nextState;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            state <= SEQ_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        reqEn_o   = 1'b0;
        busy_o    = 1'b0;
        done_o    = 1'b0;
        case (state)
            SEQ_IDLE: begin
                if (access_i) begin
                    reqEn_o   = 1'b1;
                    busy_o    = 1'b1;   // keeps the access from issuing twice
                    nextState = SEQ_WAIT;
                end
            end
            SEQ_WAIT: begin
                if (dStall_i) begin
                    busy_o = 1'b1;
                end else begin
                    done_o    = 1'b1;   // read data valid this cycle
                    nextState = SEQ_IDLE;
                end
            end
            default: nextState = SEQ_IDLE;
        endcase
    end

endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath (
    input  logic               clk,
    input  logic               rstN_i,
    output logic [`XLEN-1:0]   pcF_o,
    output logic               instEn_o,
    input  logic [31:0]        inst_i,
    output pipePkg::memReqT    memReq_o,
    input  logic [`XLEN-1:0]   memRdata_i,
    input  logic               dStall_i,
    output pipePkg::debugWbT   debugWb_o
);
    import isaPkg::*;
    import pipePkg::*;

    logic               memBusy;
    logic               memDone;
    logic               memAccess;
    logic               memReqEn;
    logic               stallFD;
    logic               loadUse;
    logic               redirectE;
    logic               jumpD;
    logic [`XLEN-1:0]   pcTarget;

    logic               dValid;
    logic [`XLEN-1:0]   pcD;
    logic [`XLEN-1:0]   pcPlus4D;
    ctrlT               ctrlD;
    logic [`XLEN-1:0]   immD;
    logic [`REG_AW-1:0] rsD;
    logic [`REG_AW-1:0] rtD;
    logic [`REG_AW-1:0] rdD;
    logic [`XLEN-1:0]   jumpIdxD;
    logic [`XLEN-1:0]   jumpTargetD;
    logic [`XLEN-1:0]   rsRfD;
    logic [`XLEN-1:0]   rtRfD;
    logic [`XLEN-1:0]   rsValD;
    logic [`XLEN-1:0]   rtValD;

    idExT               idEx;
    idExT               idExNext;
    logic [`XLEN-1:0]   aluResultE;
    logic               takenE;
    logic [`XLEN-1:0]   branchTargetE;

    exMemT              exMem;
    exMemT              exMemNext;
    logic [`XLEN-1:0]   memResultM;

    memWbT              memWb;
    memWbT              memWbNext;
    logic               wbWrite;

    // fetch
    assign stallFD   = memBusy | loadUse;
    assign instEn_o  = ~stallFD;
    assign redirectE = idEx.valid & takenE & ~memBusy;
    assign jumpD     = dValid & ctrlD.jump & ~stallFD;
    assign pcTarget  = redirectE ? branchTargetE : jumpTargetD;  // older instruction wins

    pcCounter pcUnit (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .hold_i     (stallFD),
        .redirect_i (redirectE | jumpD),
        .target_i   (pcTarget),
        .pc_o       (pcF_o)
    );

    // decode, the instruction memory itself acts as the F/D register
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            dValid <= 1'b0;
        end else if (redirectE || jumpD) begin
            dValid <= 1'b0;     // squash the fetch in flight
        end else if (!stallFD) begin
            dValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallFD) begin
            pcD <= pcF_o;
        end
    end

    decoder decodeUnit (
        .inst_i       (inst_i),
        .ctrl_o       (ctrlD),
        .imm_o        (immD),
        .rs_o         (rsD),
        .rt_o         (rtD),
        .rd_o         (rdD),
        .jumpTarget_o (jumpIdxD)
    );

    assign pcPlus4D    = pcD + `PC_STEP;
    assign jumpTargetD = jumpIdxD | {pcPlus4D[`XLEN-1:28], {28{1'b0}}};

    regFile regFileUnit (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .rs_i     (rsD),
        .rt_i     (rtD),
        .wAddr_i  (memWb.dest),
        .wEn_i    (wbWrite),
        .wData_i  (memWb.result),
        .rsData_o (rsRfD),
        .rtData_o (rtRfD)
    );

    // writeback results arrive via the regfile bypass
    function automatic logic [`XLEN-1:0] fwdOperand(input logic [`REG_AW-1:0] r,
                                                    input logic [`XLEN-1:0]   rfData);
        logic [`XLEN-1:0] v;
        v = rfData;
        if (r != '0 && exMem.valid && exMem.regWrite && exMem.dest == r) begin
            v = memResultM;
        end
        if (r != '0 && idEx.valid && idEx.ctrl.regWrite && idEx.dest == r) begin
            v = aluResultE;     // youngest producer wins
        end
        return v;
    endfunction

    always_comb begin
        rsValD = fwdOperand(rsD, rsRfD);
        rtValD = fwdOperand(rtD, rtRfD);
    end

    // load data is not ready until memory, one bubble
    assign loadUse = dValid && idEx.valid && idEx.ctrl.memRead && idEx.dest != '0 &&
                     (idEx.dest == rsD || idEx.dest == rtD);

    always_comb begin
        idExNext.valid     = dValid & ~loadUse & ~redirectE;
        idExNext.pc        = pcD;
        idExNext.ctrl      = ctrlD;
        idExNext.opA       = rsValD;
        idExNext.opB       = ctrlD.useImm ? immD : rtValD;
        idExNext.storeData = rtValD;
        idExNext.dest      = ctrlD.dstRt ? rtD : rdD;
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            idEx.valid <= 1'b0;
        end else if (!memBusy) begin
            idEx <= idExNext;
        end
    end

    // execute
    alu aluUnit (
        .op_i     (idEx.ctrl.aluOp),
        .branch_i (idEx.ctrl.branch),
        .a_i      (idEx.opA),
        .b_i      (idEx.opB),
        .cmpA_i   (idEx.opA),
        .cmpB_i   (idEx.storeData),
        .result_o (aluResultE),
        .taken_o  (takenE)
    );

    assign branchTargetE = idEx.pc + `PC_STEP + {idEx.opB[`XLEN-3:0], 2'b00};

    always_comb begin
        exMemNext.valid     = idEx.valid;
        exMemNext.pc        = idEx.pc;
        exMemNext.regWrite  = idEx.ctrl.regWrite;
        exMemNext.memRead   = idEx.ctrl.memRead;
        exMemNext.memWrite  = idEx.ctrl.memWrite;
        exMemNext.dest      = idEx.dest;
        exMemNext.result    = aluResultE;
        exMemNext.storeData = idEx.storeData;
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            exMem.valid <= 1'b0;
        end else if (!memBusy) begin
            exMem <= exMemNext;
        end
    end

    // memory
    assign memAccess = exMem.valid & (exMem.memRead | exMem.memWrite);

    memAccessSeq memSeq (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .access_i (memAccess),
        .dStall_i (dStall_i),
        .reqEn_o  (memReqEn),
        .busy_o   (memBusy),
        .done_o   (memDone)
    );

    always_comb begin
        memReq_o.en    = memReqEn;
        memReq_o.we    = exMem.memWrite;
        memReq_o.addr  = exMem.result;
        memReq_o.wdata = exMem.storeData;
    end

    assign memResultM = (exMem.memRead && memDone) ? memRdata_i : exMem.result;

    always_comb begin
        memWbNext.valid    = exMem.valid;
        memWbNext.pc       = exMem.pc;
        memWbNext.regWrite = exMem.regWrite;
        memWbNext.dest     = exMem.dest;
        memWbNext.result   = memResultM;
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            memWb.valid <= 1'b0;
        end else if (!memBusy) begin
            memWb <= memWbNext;
        end
    end

    // writeback is held with the rest, so retire only once
    assign wbWrite = memWb.valid & memWb.regWrite & ~memBusy;

    always_comb begin
        debugWb_o.pc    = memWb.pc;
        debugWb_o.wen   = wbWrite;
        debugWb_o.wnum  = memWb.dest;
        debugWb_o.wdata = memWb.result;
    end

endmodule

/* sim/tbMemModel.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tbMemModel (
    input  logic               clk,
    input  logic [`XLEN-1:0]   pc_i,
    input  logic               instEn_i,
    input  pipePkg::memReqT    memReq_i,
    input  logic [1:0]         waitLen_i,
    output logic [31:0]        inst_o,
    output logic [`XLEN-1:0]   rdata_o,
    output logic               dStall_o
);

    logic [31:0] imem [256];             // program words from RESET_PC up
    logic [31:0] dmem [logic [29:0]];    // keyed by word address
    logic [1:0]  waitCnt;

    function automatic logic [31:0] fetchWord(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] offset;
        offset = addr - `RESET_PC;
        if (offset < 32'd1024) begin
            return imem[offset[9:2]];
        end
        return 32'h0;    // outside the program reads as nop
    endfunction

    // unwritten words read back a pattern of the full address
    function automatic logic [31:0] readWord(input logic [`XLEN-1:0] addr);
        if (dmem.exists(addr[31:2])) begin
            return dmem[addr[31:2]];
        end
        return addr ^ 32'h5EED_F00D;
    endfunction

    initial begin
        inst_o   = 32'h0;
        rdata_o  = '0;
        dStall_o = 1'b0;
        waitCnt  = 2'd0;
    end

    always @(posedge clk) begin
        if (instEn_i) begin
            inst_o <= fetchWord(pc_i);
        end
        if (memReq_i.en) begin
            if (memReq_i.we) begin
                dmem[memReq_i.addr[31:2]] = memReq_i.wdata;
            end else begin
                rdata_o <= readWord(memReq_i.addr);    // held until the next read
            end
            waitCnt  <= waitLen_i;
            dStall_o <= (waitLen_i != 2'd0);
        end else if (waitCnt != 2'd0) begin
            waitCnt  <= waitCnt - 2'd1;
            dStall_o <= (waitCnt > 2'd1);
        end
    end

endmodule

/* sim/tbDatapath.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tbDatapath;
    import pipePkg::*;

    // MIPS32 encodings
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0D;
    localparam logic [5:0] OPC_LUI     = 6'h0F;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2B;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_SLT      = 6'h2A;

    localparam logic [4:0] MARKER_REG     = 5'd31;   // only killed instructions write it
    localparam int         TIMEOUT_CYCLES = 500;

    logic               clk;
    logic               rstN;
    logic [`XLEN-1:0]   pcF;
    logic               instEn;
    logic [31:0]        inst;
    memReqT             memReq;
    logic [`XLEN-1:0]   memRdata;
    logic               dStall;
    debugWbT            debugWb;
    logic [1:0]         waitLen;

    logic [15:0]        lfsr = 16'd46536;
    logic [31:0]        refReg [32];
    int                 progLen;
    debugWbT            expQ [$];
    debugWbT            obsQ [$];
    memReqT             reqQ [$];
    logic               reqEnPrev = 1'b0;
    int                 errorCount = 0;
    int                 testsRun = 0;
    int                 testsFailed = 0;

    // section ends in expQ and addresses the checks look for
    int                 arithEnd;
    int                 memEnd;
    int                 branchEnd;
    int                 jumpEnd;
    logic [31:0]        storeAddr;
    logic [31:0]        storeWord;
    logic [31:0]        beqTarget;
    logic [31:0]        bnePc;
    logic [31:0]        jumpTarget;

    datapath datapath_i (
        .clk        (clk),
        .rstN_i     (rstN),
        .pcF_o      (pcF),
        .instEn_o   (instEn),
        .inst_i     (inst),
        .memReq_o   (memReq),
        .memRdata_i (memRdata),
        .dStall_i   (dStall),
        .debugWb_o  (debugWb)
    );

    tbMemModel memModel (
        .clk       (clk),
        .pc_i      (pcF),
        .instEn_i  (instEn),
        .memReq_i  (memReq),
        .waitLen_i (waitLen),
        .inst_o    (inst),
        .rdata_o   (memRdata),
        .dStall_o  (dStall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // feedback taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] opc, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] pcOf(input int idx);
        return `RESET_PC + 32'(idx) * `PC_STEP;
    endfunction

    function automatic logic [31:0] sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] sltRef(input logic [31:0] a, input logic [31:0] b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    task automatic putInst(input logic [31:0] word);
        memModel.imem[8'(progLen)] = word;
        progLen++;
    endtask

    // instruction that must retire with this register write
    task automatic putWrite(input logic [31:0] word, input logic [4:0] dst,
                            input logic [31:0] value);
        debugWbT e;
        e.pc    = pcOf(progLen);
        e.wen   = 1'b1;
        e.wnum  = dst;
        e.wdata = value;
        putInst(word);
        refReg[dst] = value;
        expQ.push_back(e);
    endtask

    task automatic buildProgram();
        logic [15:0] imm;
        logic [31:0] marker;
        for (int k = 0; k < 256; k++) begin
            memModel.imem[8'(k)] = 32'h0;
        end
        for (int r = 0; r < 32; r++) begin
            refReg[5'(r)] = 32'h0;
        end
        progLen = 0;
        marker  = encI(OPC_ADDIU, 5'd0, MARKER_REG, 16'h0BAD);

        // every operand comes from the previous few results
        imm = 16'(randBits(16));
        putWrite(encI(OPC_ADDIU, 5'd0, 5'd1, imm), 5'd1, sext(imm));
        imm = 16'(randBits(16));
        putWrite(encI(OPC_LUI, 5'd0, 5'd2, imm), 5'd2, {imm, 16'h0});
        imm = 16'(randBits(16));
        putWrite(encI(OPC_ORI, 5'd2, 5'd2, imm), 5'd2, refReg[2] | {16'h0, imm});
        putWrite(encR(FN_ADDU, 5'd3, 5'd1, 5'd2), 5'd3, refReg[1] + refReg[2]);
        putWrite(encR(FN_SUBU, 5'd4, 5'd3, 5'd1), 5'd4, refReg[3] - refReg[1]);
        putWrite(encR(FN_AND, 5'd5, 5'd4, 5'd3), 5'd5, refReg[4] & refReg[3]);
        putWrite(encR(FN_OR, 5'd6, 5'd5, 5'd2), 5'd6, refReg[5] | refReg[2]);
        putWrite(encR(FN_SLT, 5'd7, 5'd6, 5'd1), 5'd7, sltRef(refReg[6], refReg[1]));
        putWrite(encR(FN_SLT, 5'd8, 5'd1, 5'd6), 5'd8, sltRef(refReg[1], refReg[6]));
        imm = 16'(randBits(16));
        putWrite(encI(OPC_ADDIU, 5'd7, 5'd9, imm), 5'd9, refReg[7] + sext(imm));
        arithEnd = expQ.size();

        // sw then lw of the same word and a load-use addu after them
        putWrite(encI(OPC_ADDIU, 5'd0, 5'd10, 16'h0100), 5'd10, 32'h100);
        imm       = {6'd0, 8'(randBits(8)), 2'b00};
        storeAddr = refReg[10] + sext(imm);
        storeWord = refReg[3];
        putInst(encI(OPC_SW, 5'd10, 5'd3, imm));
        putWrite(encI(OPC_LW, 5'd10, 5'd11, imm), 5'd11, storeWord);
        putWrite(encR(FN_ADDU, 5'd12, 5'd11, 5'd1), 5'd12, refReg[11] + refReg[1]);
        memEnd = expQ.size();

        putWrite(encI(OPC_ADDIU, 5'd0, 5'd13, 16'd5), 5'd13, 32'd5);
        beqTarget = pcOf(progLen) + 32'd4 + (32'd3 << 2);
        putInst(encI(OPC_BEQ, 5'd13, 5'd13, 16'd3));    // taken over three markers
        repeat (3) putInst(marker);
        putWrite(encI(OPC_ADDIU, 5'd13, 5'd14, 16'd1), 5'd14, refReg[13] + 32'd1);
        bnePc = pcOf(progLen);
        putInst(encI(OPC_BNE, 5'd14, 5'd14, 16'd2));    // equal operands so it falls through
        putWrite(encI(OPC_ADDIU, 5'd0, 5'd30, 16'h7E57), 5'd30, 32'h7E57);
        putWrite(encR(FN_ADDU, 5'd15, 5'd14, 5'd30), 5'd15, refReg[14] + refReg[30]);
        branchEnd = expQ.size();

        jumpTarget = pcOf(progLen + 3);
        putInst({OPC_J, jumpTarget[27:2]});
        repeat (2) putInst(marker);
        imm = 16'(randBits(16));
        putWrite(encI(OPC_ADDIU, 5'd0, 5'd16, imm), 5'd16, sext(imm));
        putWrite(encR(FN_ADDU, 5'd17, 5'd16, 5'd15), 5'd17, refReg[16] + refReg[15]);
        jumpEnd = expQ.size();
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            errorCount++;
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic flagFailure(input string msg);
        errorCount++;
        $display("%s", msg);
    endtask

    task automatic compareRange(input string testName, input int lo, input int hi);
        for (int i = lo; i < hi; i++) begin
            checkValue(testName, $sformatf("write %0d pc", i), expQ[i].pc, obsQ[i].pc);
            checkValue(testName, $sformatf("write %0d reg", i),
                       32'(expQ[i].wnum), 32'(obsQ[i].wnum));
            checkValue(testName, $sformatf("write %0d data", i), expQ[i].wdata, obsQ[i].wdata);
        end
    endtask

    task automatic waitForRetired(input string testName, input int count,
                                  output logic reached);
        int cycles;
        cycles = 0;
        while (obsQ.size() < count && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        reached = (obsQ.size() >= count);
        if (!reached) begin
            flagFailure($sformatf("%s timed out: %0d of %0d register writes retired after %0d cycles",
                                  testName, obsQ.size(), count, cycles));
        end
    endtask

    task automatic reportTest(input string testName, input int errBefore);
        testsRun++;
        if (errorCount == errBefore) begin
            $display("PASS  %s", testName);
        end else begin
            testsFailed++;
            $display("FAIL  %s (%0d errors)", testName, errorCount - errBefore);
        end
    endtask

    always @(posedge clk) begin
        if (rstN) begin
            waitLen <= 2'(randBits(2));    // 0 to 3 stall cycles per access
        end
    end

    // retire trace and bus rules sampled mid-cycle
    always @(negedge clk) begin
        if (!rstN) begin
            assert (!memReq.en && !debugWb.wen)
                else flagFailure("data request or register write active during reset");
        end else begin
            assert (!(memReq.en && reqEnPrev))
                else flagFailure("data request enable stayed high for two cycles");
            assert (!(memReq.en && dStall))
                else flagFailure("data request issued while the memory was stalling");
            assert (!(dStall && instEn))
                else flagFailure("fetch enabled while the data memory was stalling");
            if (memReq.en) begin
                reqQ.push_back(memReq);
            end
            if (debugWb.wen) begin
                assert (debugWb.wnum != MARKER_REG)
                    else flagFailure($sformatf("killed instruction at %h retired", debugWb.pc));
                obsQ.push_back(debugWb);
            end
        end
        reqEnPrev = memReq.en;
    end

    initial begin
        int   errBefore;
        logic reached;
        rstN    = 1'b0;
        waitLen = 2'd0;
        buildProgram();

        errBefore = errorCount;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("reset", "instEn_o", 32'd1, 32'(instEn));
        checkValue("reset", "first fetch pc", `RESET_PC, pcF);
        @(posedge clk);
        reportTest("reset", errBefore);

        errBefore = errorCount;
        waitForRetired("arith", arithEnd, reached);
        if (reached) begin
            compareRange("arith", 0, arithEnd);
            for (int i = 1; i < arithEnd; i++) begin
                checkValue("arith", $sformatf("pc step %0d", i), `PC_STEP,
                           obsQ[i].pc - obsQ[i-1].pc);
            end
        end
        reportTest("arith", errBefore);

        errBefore = errorCount;
        waitForRetired("loadStore", memEnd, reached);
        if (reached) begin
            compareRange("loadStore", arithEnd, memEnd);
        end
        checkValue("loadStore", "request pulses", 32'd2, 32'(reqQ.size()));
        if (reqQ.size() == 2) begin
            checkValue("loadStore", "sw we", 32'd1, 32'(reqQ[0].we));
            checkValue("loadStore", "sw addr", storeAddr, reqQ[0].addr);
            checkValue("loadStore", "sw data", storeWord, reqQ[0].wdata);
            checkValue("loadStore", "lw we", 32'd0, 32'(reqQ[1].we));
            checkValue("loadStore", "lw addr", storeAddr, reqQ[1].addr);
        end
        reportTest("loadStore", errBefore);

        errBefore = errorCount;
        waitForRetired("branch", branchEnd, reached);
        if (reached) begin
            compareRange("branch", memEnd, branchEnd);
            checkValue("branch", "pc after taken beq", beqTarget, obsQ[memEnd + 1].pc);
            checkValue("branch", "pc after untaken bne", bnePc + `PC_STEP,
                       obsQ[memEnd + 2].pc);
        end
        reportTest("branch", errBefore);

        errBefore = errorCount;
        waitForRetired("jump", jumpEnd, reached);
        if (reached) begin
            compareRange("jump", branchEnd, jumpEnd);
            checkValue("jump", "pc after j", jumpTarget, obsQ[branchEnd].pc);
        end
        checkValue("jump", "request pulses", 32'd2, 32'(reqQ.size()));
        reportTest("jump", errBefore);

        $display("summary: %0d tests, %0d failing, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/pcCounter.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/memAccessSeq.sv
rtl/datapath.sv
sim/tbMemModel.sv
sim/tbDatapath.sv

/* build.sh */
#!/bin/sh
# builds the pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -f build.f --top-module tbDatapath -Mdir "$OBJ"; then
    echo "verilator build failed"
    exit 1
fi

if ! "./$OBJ/VtbDatapath" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    exit 0
fi
exit 1
